// File: all.f
merge_pkg.sv
run_fifo.sv
head_decode.sv
merge_control.sv
merge_execute.sv
merge_result.sv
merge_top.sv
merge_sva.sv
tb_merge_top.sv

// File: Bender.yml
package:
  name: merge_unit

sources:
  - merge_pkg.sv
  - run_fifo.sv
  - head_decode.sv
  - merge_control.sv
  - merge_execute.sv
  - merge_result.sv
  - merge_top.sv
  - target: test
    files:
      - merge_sva.sv
      - tb_merge_top.sv

// File: tb_merge_top.sv
`timescale 1ns/1ps

module tb_merge_top;

   localparam int ROW_KEYS = 4;  // Keys per run in one table row, at most.
   localparam int MAX_ROWS = 8;
   localparam int KW       = merge_pkg::KEY_W;

   // One table row. Key 0 sits in the low bits.
   typedef struct packed {
      logic [ROW_KEYS-1:0][KW-1:0] a_keys;
      logic [ROW_KEYS-1:0][KW-1:0] b_keys;
      logic [2:0]                  a_cnt;  // Keys in the run of A.
      logic [2:0]                  b_cnt;
      logic                        bp;     // Random back-pressure on i_out_full.
   } row_t;

   logic          i_clk = 1'b0;
   logic          i_rst_n;
   logic          i_a_wr;
   logic [KW-1:0] i_a_key;
   logic          i_b_wr;
   logic [KW-1:0] i_b_key;
   logic          i_out_full;
   logic          o_a_full;
   logic          o_b_full;
   logic          o_out_wr;
   logic [KW-1:0] o_out_key;
   logic          o_out_sep;
   logic          o_bank;

   row_t          rows [MAX_ROWS];       // Test table.
   string         row_names [MAX_ROWS];
   int            num_rows;
   logic [KW:0]   exp_q [$];             // Expected {sep, key} words.
   logic [KW:0]   exp_word;
   logic          exp_bank;              // Bank the model expects on the pins.
   string         cur_name;              // Test in progress.
   int            err_cnt;               // Failed checks over the run.
   int            pass_cnt;
   int            fail_cnt;
   int            cycle_cnt = 0;
   int            cycle_limit = 0;       // Zero until the table is loaded.
   integer        seed;
   logic          bp_on;

   always #10 i_clk = ~i_clk;  // 20 ns period.

   merge_top i_merge_top (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_a_wr(i_a_wr), .i_a_key(i_a_key), .i_b_wr(i_b_wr), .i_b_key(i_b_key),
      .i_out_full(i_out_full), .o_a_full(o_a_full), .o_b_full(o_b_full),
      .o_out_wr(o_out_wr), .o_out_key(o_out_key), .o_out_sep(o_out_sep),
      .o_bank(o_bank)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Helpers.
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [ROW_KEYS*KW-1:0] keys4(input logic [KW-1:0] k0, k1, k2, k3);
      keys4 = {k3, k2, k1, k0};  // First key lands in slot 0.
   endfunction

   task automatic add_row(input string name, input logic [ROW_KEYS*KW-1:0] a, input int na,
                          input logic [ROW_KEYS*KW-1:0] b, input int nb, input logic bp);
      rows[num_rows]      = '{a_keys: a, b_keys: b, a_cnt: 3'(na), b_cnt: 3'(nb), bp: bp};
      row_names[num_rows] = name;
      num_rows++;
   endtask

   // Two-way merge of the row, ties to A, then the run separator.
   task automatic build_expected(input row_t r);
      int i;
      int j;
      i = 0;
      j = 0;
      while (i < r.a_cnt && j < r.b_cnt) begin
         if (r.a_keys[i] <= r.b_keys[j]) begin
            exp_q.push_back({1'b0, r.a_keys[i]});
            i++;
         end else begin
            exp_q.push_back({1'b0, r.b_keys[j]});
            j++;
         end
      end
      for (; i < r.a_cnt; i++) exp_q.push_back({1'b0, r.a_keys[i]});  // Tail of A.
      for (; j < r.b_cnt; j++) exp_q.push_back({1'b0, r.b_keys[j]});  // Tail of B.
      exp_q.push_back({1'b1, merge_pkg::SEP_KEY});
   endtask

   task automatic check_val(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
      if (actual !== expected) begin
         err_cnt++;
         $display("FAIL %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
      end
   endtask

   // Step to 2 ns past the next rising edge and redraw back-pressure.
   task automatic next_cycle();
      @(posedge i_clk);
      #2;
      i_out_full = bp_on ? 1'($random(seed)) : 1'b0;
   endtask

   task automatic run_row(input int idx);
      row_t r;
      int   k;
      int   errs_before;
      r           = rows[idx];
      cur_name    = row_names[idx];
      errs_before = err_cnt;
      build_expected(r);
      bp_on = r.bp;
      // Run words then separator, one word per FIFO per cycle.
      for (k = 0; k <= ROW_KEYS; k++) begin
         // A run and its separator never reach the FIFO depth.
         check_val("a_full", 1'b0, o_a_full);
         check_val("b_full", 1'b0, o_b_full);
         i_a_wr  = (k <= r.a_cnt);
         i_a_key = (k < r.a_cnt) ? r.a_keys[k] : merge_pkg::SEP_KEY;
         i_b_wr  = (k <= r.b_cnt);
         i_b_key = (k < r.b_cnt) ? r.b_keys[k] : merge_pkg::SEP_KEY;
         next_cycle();
      end
      i_a_wr = 1'b0;
      i_b_wr = 1'b0;
      while (exp_q.size() != 0) next_cycle();  // Watchdog ends a hang.
      bp_on      = 1'b0;
      i_out_full = 1'b0;
      repeat (2) next_cycle();  // Bank flips one cycle after the separator.
      check_val("bank", exp_bank, o_bank);
      if (err_cnt == errs_before) begin
         pass_cnt++;
         $display("Test %s: passed", cur_name);
      end else begin
         fail_cnt++;
         $display("Test %s: failed with %0d errors", cur_name, err_cnt - errs_before);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Output monitor and watchdog.
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge i_clk) begin  // Outputs settle well before the falling edge.
      if (i_rst_n && o_out_wr) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("Unexpected output word %0h written during test %s", o_out_key, cur_name);
         end else begin
            exp_word = exp_q.pop_front();
            check_val("key", exp_word[KW-1:0], o_out_key);
            check_val("sep", exp_word[KW], o_out_sep);
            check_val("bank", exp_bank, o_bank);
            if (exp_word[KW]) exp_bank = ~exp_bank;  // Next pass, other bank.
         end
      end
   end

   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout in test %s: the merge output stalled after %0d cycles",
                  cur_name, cycle_cnt);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int total_words;
      int t;
      seed       = 32'h238f;
      i_rst_n    = 1'b0;
      i_a_wr     = 1'b0;
      i_a_key    = '0;
      i_b_wr     = 1'b0;
      i_b_key    = '0;
      i_out_full = 1'b0;
      bp_on      = 1'b0;
      exp_bank   = 1'b0;
      num_rows   = 0;
      err_cnt    = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      cur_name   = "reset";
      add_row("interleave",  keys4(3, 7, 9, 0),      3, keys4(1, 8, 0, 0),       2, 1'b0);
      add_row("ties",        keys4(2, 4, 4, 6),      4, keys4(2, 4, 6, 0),       3, 1'b0);
      add_row("empty_a",     keys4(0, 0, 0, 0),      0, keys4(2, 5, 0, 0),       2, 1'b0);
      add_row("backpress",   keys4(1, 5, 9, 12),     4, keys4(2, 3, 10, 11),     4, 1'b1);
      add_row("empty_b",     keys4(4, 8, 0, 0),      2, keys4(0, 0, 0, 0),       0, 1'b0);
      add_row("backpress_2", keys4(10, 20, 30, 0),   3, keys4(15, 25, 35, 45),   4, 1'b1);
      total_words = 0;
      for (t = 0; t < num_rows; t++) begin
         total_words += rows[t].a_cnt + rows[t].b_cnt + 2;  // Both separators too.
      end
      cycle_limit = total_words * 4 + 100;
      repeat (4) @(posedge i_clk);
      #2;
      i_rst_n = 1'b1;
      for (t = 0; t < num_rows; t++) run_row(t);
      $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
               pass_cnt, fail_cnt, i_merge_top.u_merge_sva.assert_fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && i_merge_top.u_merge_sva.assert_fail_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: merge_sva.sv
`timescale 1ns/1ps

module merge_sva (
   input logic                        i_clk,
   input logic                        i_rst_n,
   input logic                        i_out_full,
   input logic                        o_out_wr,
   input logic [merge_pkg::KEY_W-1:0] o_out_key,
   input logic                        o_out_sep,
   input logic                        o_bank
);

   int                          assert_fail_cnt = 0;  // Read by the testbench.
   logic [merge_pkg::KEY_W-1:0] last_key;             // Previous key of the open run.
   logic                        in_run;               // Open run has a key out.

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         last_key <= '0;
         in_run   <= 1'b0;
      end else if (o_out_wr) begin
         last_key <= o_out_key;
         in_run   <= ~o_out_sep;  // Separator closes the run.
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output rules.
   ////////////////////////////////////////////////////////////////////////////

   a_keys_ascend: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_out_wr && !o_out_sep && in_run) |-> (o_out_key >= last_key))
      else begin assert_fail_cnt++; $error("Key fell inside a run."); end

   a_bank_after_sep: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $changed(o_bank) |-> $past(o_out_wr && o_out_sep))
      else begin assert_fail_cnt++; $error("Bank moved without a separator write."); end

   a_no_wr_after_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_out_full |=> !o_out_wr)
      else begin assert_fail_cnt++; $error("Word written after back-pressure."); end

endmodule

bind merge_top merge_sva u_merge_sva (
   .i_clk(i_clk), .i_rst_n(i_rst_n), .i_out_full(i_out_full),
   .o_out_wr(o_out_wr), .o_out_key(o_out_key), .o_out_sep(o_out_sep), .o_bank(o_bank)
);

// File: merge_top.sv
`timescale 1ns/1ps

module merge_top (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  logic                        i_a_wr,      // Stream A write strobe.
   input  logic [merge_pkg::KEY_W-1:0] i_a_key,
   input  logic                        i_b_wr,      // Stream B write strobe.
   input  logic [merge_pkg::KEY_W-1:0] i_b_key,
   input  logic                        i_out_full,  // Downstream back-pressure.
   output logic                        o_a_full,
   output logic                        o_b_full,
   output logic                        o_out_wr,
   output logic [merge_pkg::KEY_W-1:0] o_out_key,
   output logic                        o_out_sep,
   output logic                        o_bank
);

   logic [merge_pkg::KEY_W-1:0] a_head;      // Head of FIFO A.
   logic [merge_pkg::KEY_W-1:0] b_head;      // Head of FIFO B.
   logic                        a_empty;
   logic                        b_empty;
   logic                        a_pop;
   logic                        b_pop;
   merge_pkg::head_flags_t      flags;       // Decode to control.
   merge_pkg::merge_cmd_t       cmd;         // Control to execute.
   merge_pkg::out_word_t        word;        // Execute to result.
   logic                        word_valid;

   ////////////////////////////////////////////////////////////////////////////
   // Input FIFOs.
   ////////////////////////////////////////////////////////////////////////////

   run_fifo u_fifo_a (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wr(i_a_wr), .i_key(i_a_key), .i_pop(a_pop),
      .o_head(a_head), .o_empty(a_empty), .o_full(o_a_full)
   );

   run_fifo u_fifo_b (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wr(i_b_wr), .i_key(i_b_key), .i_pop(b_pop),
      .o_head(b_head), .o_empty(b_empty), .o_full(o_b_full)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Decode, control, execute and result.
   ////////////////////////////////////////////////////////////////////////////

   head_decode u_head_decode (
      .i_a_head(a_head), .i_b_head(b_head),
      .i_a_empty(a_empty), .i_b_empty(b_empty),
      .o_flags(flags)
   );

   merge_control u_merge_control (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_flags(flags), .i_out_full(i_out_full),
      .o_cmd(cmd), .o_stall()
   );

   merge_execute u_merge_execute (
      .i_a_head(a_head), .i_b_head(b_head), .i_cmd(cmd),
      .o_a_pop(a_pop), .o_b_pop(b_pop),
      .o_word(word), .o_word_valid(word_valid)
   );

   merge_result u_merge_result (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_word(word), .i_word_valid(word_valid),
      .o_out_wr(o_out_wr), .o_out_key(o_out_key),
      .o_out_sep(o_out_sep), .o_bank(o_bank)
   );

endmodule

// File: merge_result.sv
`timescale 1ns/1ps

module merge_result (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  merge_pkg::out_word_t        i_word,        // Word from execute.
   input  logic                        i_word_valid,  // Write i_word.
   output logic                        o_out_wr,      // Output strobe.
   output logic [merge_pkg::KEY_W-1:0] o_out_key,     // Output key.
   output logic                        o_out_sep,     // Output word is a separator.
   output logic                        o_bank         // Destination bank select.
);

   merge_pkg::out_word_t r_word;  // Word on the output pins.

   ////////////////////////////////////////////////////////////////////////////
   // Output word register.
   ////////////////////////////////////////////////////////////////////////////

   // Loaded only on a write, so the pins hold the last word between strobes.
   always_ff @(posedge i_clk) begin
      if (i_word_valid) begin
         r_word <= i_word;
      end
   end

   assign o_out_key = r_word.data;
   assign o_out_sep = r_word.sep;

   ////////////////////////////////////////////////////////////////////////////
   // Strobe and bank flag.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_out_wr <= 1'b0;
         o_bank   <= 1'b0;  // First pass goes to bank 0.
      end else begin
         o_out_wr <= i_word_valid;  // One cycle after the decision.
         // The bank moves the cycle after the separator is on the pins.
         if (o_out_wr && r_word.switch_bank) begin
            o_bank <= ~o_bank;
         end
      end
   end

endmodule

// File: merge_execute.sv
`timescale 1ns/1ps

module merge_execute (
   input  logic [merge_pkg::KEY_W-1:0] i_a_head,      // Head key of A.
   input  logic [merge_pkg::KEY_W-1:0] i_b_head,      // Head key of B.
   input  merge_pkg::merge_cmd_t       i_cmd,         // Issue from control.
   output logic                        o_a_pop,       // Pop strobe to FIFO A.
   output logic                        o_b_pop,       // Pop strobe to FIFO B.
   output merge_pkg::out_word_t        o_word,        // Word for the result stage.
   output logic                        o_word_valid   // o_word is to be written.
);

   logic [merge_pkg::KEY_W-1:0] key_sel;  // Key taken from the popped side.

   ////////////////////////////////////////////////////////////////////////////
   // FIFO pops.
   ////////////////////////////////////////////////////////////////////////////

   // Pops leave in the decision cycle. The heads move on at the next edge.
   assign o_a_pop = i_cmd.pop_a;
   assign o_b_pop = i_cmd.pop_b;

   ////////////////////////////////////////////////////////////////////////////
   // Output word.
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (i_cmd.emit_sep) begin
         key_sel = merge_pkg::SEP_KEY;  // Both heads are separators here.
      end else if (i_cmd.pop_a) begin
         key_sel = i_a_head;
      end else begin
         key_sel = i_b_head;            // B popped, or nothing issued.
      end
   end

   always_comb begin
      o_word             = '0;
      o_word.data        = key_sel;
      o_word.sep         = i_cmd.emit_sep;     // Marks the run end downstream.
      o_word.switch_bank = i_cmd.switch_bank;  // Only set with the separator.
   end

   assign o_word_valid = i_cmd.emit | i_cmd.emit_sep;  // One word per issue at most.

endmodule

// File: merge_control.sv
`timescale 1ns/1ps

module merge_control (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  merge_pkg::head_flags_t i_flags,     // Head status from decode.
   input  logic                   i_out_full,  // Downstream cannot take a word.
   output merge_pkg::merge_cmd_t  o_cmd,       // Issue slot for execute.
   output logic                   o_stall      // Nothing issued this cycle.
);

   merge_pkg::merge_state_e state;       // Current merge state.
   merge_pkg::merge_state_e next_state;  // State once this cycle issues.
   merge_pkg::merge_cmd_t   cmd;         // Command before the stall gate.
   logic                    need_stall;  // Out full or a needed FIFO empty.

   ////////////////////////////////////////////////////////////////////////////
   // Next state and source choice.
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      cmd        = '0;
      need_stall = i_out_full;  // Back-pressure stops every state.
      case (state)
         merge_pkg::NOMINAL: begin
            need_stall = need_stall | i_flags.a_empty | i_flags.b_empty;
            if (i_flags.a_sep) begin
               next_state = merge_pkg::DONE_A;  // Run of A ended, B drains.
            end else if (i_flags.b_sep) begin
               next_state = merge_pkg::DONE_B;  // Mirror case.
            end else begin
               cmd.pop_a = i_flags.a_lte_b;     // Ties go to A.
               cmd.pop_b = ~i_flags.a_lte_b;
               cmd.emit  = 1'b1;
            end
         end
         merge_pkg::DONE_A: begin
            need_stall = need_stall | i_flags.b_empty;  // Only B is read here.
            if (i_flags.b_sep) begin
               next_state = merge_pkg::TOGGLE;  // Both sides now on a separator.
            end else begin
               cmd.pop_b = 1'b1;
               cmd.emit  = 1'b1;
            end
         end
         merge_pkg::DONE_B: begin
            need_stall = need_stall | i_flags.a_empty;  // Only A is read here.
            if (i_flags.a_sep) begin
               next_state = merge_pkg::TOGGLE;
            end else begin
               cmd.pop_a = 1'b1;
               cmd.emit  = 1'b1;
            end
         end
         default: begin  // TOGGLE reads both heads.
            need_stall = need_stall | i_flags.a_empty | i_flags.b_empty;
            if (i_flags.a_sep && i_flags.b_sep) begin
               cmd.pop_a       = 1'b1;  // Drop both separators at once.
               cmd.pop_b       = 1'b1;
               cmd.emit_sep    = 1'b1;  // One separator goes out for the pair.
               cmd.switch_bank = 1'b1;
               next_state      = merge_pkg::NOMINAL;
            end else if (i_flags.a_sep) begin
               next_state = merge_pkg::DONE_A;  // Leading separator on A only.
            end else if (i_flags.b_sep) begin
               next_state = merge_pkg::DONE_B;  // Leading separator on B only.
            end else begin
               next_state = merge_pkg::NOMINAL; // Fresh runs on both sides.
            end
         end
      endcase
   end

   // A stalled cycle issues nothing.
   assign o_cmd   = need_stall ? '0 : cmd;
   assign o_stall = need_stall;

   ////////////////////////////////////////////////////////////////////////////
   // State register.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= merge_pkg::TOGGLE;  // Start as if a run pair just closed.
      end else if (!need_stall) begin
         state <= next_state;         // Held while stalled.
      end
   end

endmodule

// File: head_decode.sv
`timescale 1ns/1ps

module head_decode (
   input  logic [merge_pkg::KEY_W-1:0] i_a_head,   // Head key of A.
   input  logic [merge_pkg::KEY_W-1:0] i_b_head,   // Head key of B.
   input  logic                        i_a_empty,
   input  logic                        i_b_empty,
   output merge_pkg::head_flags_t      o_flags
);

   // An empty FIFO shows a stale head, so it never reads as a run end.
   assign o_flags.a_sep   = ~i_a_empty & (i_a_head == merge_pkg::SEP_KEY);
   assign o_flags.b_sep   = ~i_b_empty & (i_b_head == merge_pkg::SEP_KEY);
   assign o_flags.a_empty = i_a_empty;
   assign o_flags.b_empty = i_b_empty;
   assign o_flags.a_lte_b = (i_a_head <= i_b_head);  // Equal keys count for A.

endmodule

// File: run_fifo.sv
`timescale 1ns/1ps

module run_fifo (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  logic                        i_wr,     // Write strobe.
   input  logic [merge_pkg::KEY_W-1:0] i_key,    // Key to store.
   input  logic                        i_pop,    // Consume the head.
   output logic [merge_pkg::KEY_W-1:0] o_head,   // Oldest key, no pop needed.
   output logic                        o_empty,
   output logic                        o_full
);

   logic [merge_pkg::KEY_W-1:0] mem [merge_pkg::FIFO_DEPTH];  // Circular key store.
   logic [merge_pkg::PTR_W-1:0] wr_ptr;                       // Next slot to fill.
   logic [merge_pkg::PTR_W-1:0] rd_ptr;                       // Slot of the head.
   logic [merge_pkg::CNT_W-1:0] count;                        // Words held.
   logic                        wr_ok;                        // Write accepted.
   logic                        pop_ok;                       // Pop accepted.

   assign o_empty = (count == '0);
   assign o_full  = (count == merge_pkg::FIFO_FULL_CNT);

   assign wr_ok  = i_wr & ~o_full;     // A write into a full FIFO is dropped.
   assign pop_ok = i_pop & ~o_empty;   // A pop of an empty FIFO is ignored.

   assign o_head = mem[rd_ptr];        // Head shows one cycle after its write.

   ////////////////////////////////////////////////////////////////////////////
   // Storage.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= i_key;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and fill count.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= (wr_ptr == merge_pkg::LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= (rd_ptr == merge_pkg::LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         // Write and pop together leave the count alone.
         case ({wr_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: merge_pkg.sv
package merge_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes and key encoding.
   ////////////////////////////////////////////////////////////////////////////

   localparam int KEY_W      = 16;                      // Key width in bits.
   localparam int FIFO_DEPTH = 8;                       // Entries per input FIFO.
   localparam int PTR_W      = $clog2(FIFO_DEPTH);      // FIFO pointer width.
   localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);  // Fill count, 0 up to depth.

   localparam logic [KEY_W-1:0] SEP_KEY       = '0;                    // Run end marker.
   localparam logic [PTR_W-1:0] LAST_PTR      = PTR_W'(FIFO_DEPTH - 1); // Wrap point.
   localparam logic [CNT_W-1:0] FIFO_FULL_CNT = CNT_W'(FIFO_DEPTH);     // Count when full.

   ////////////////////////////////////////////////////////////////////////////
   // Control states, same encoding as the original merge control.
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      TOGGLE  = 2'b00,  // Close the run pair with one separator.
      NOMINAL = 2'b01,  // Both runs open, take the smaller head.
      DONE_A  = 2'b10,  // A sits on its separator, drain B.
      DONE_B  = 2'b11   // B sits on its separator, drain A.
   } merge_state_e;

   // Head status seen by the control.
   typedef struct packed {
      logic a_sep;    // Head of A is a separator.
      logic b_sep;    // Head of B is a separator.
      logic a_empty;  // FIFO A holds nothing.
      logic b_empty;  // FIFO B holds nothing.
      logic a_lte_b;  // Head key of A is not above that of B.
   } head_flags_t;

   // One issue slot from control to execute.
   typedef struct packed {
      logic pop_a;        // Consume the head of A.
      logic pop_b;        // Consume the head of B.
      logic emit;         // Write the popped key.
      logic emit_sep;     // Write a separator.
      logic switch_bank;  // Flip the bank after this word.
   } merge_cmd_t;

   // Word handed from execute to result.
   typedef struct packed {
      logic [KEY_W-1:0] data;         // Key or SEP_KEY.
      logic             sep;          // Word closes a run.
      logic             switch_bank;  // Bank flips once this word is out.
   } out_word_t;

endpackage
